/* design/ext_pkg.sv */
// ext_pkg: widths, opcode and ALU function enums, and the request, decode and result structs.

package ext_pkg;

  // data path and address width of the extension.
  localparam int WORD_W = 32;

  // width of the immediate carried with each request.
  localparam int IMM_W = 8;

  // width of the stall counter.
  // a stalled add runs for the low STALL_W immediate bits plus one cycles.
  localparam int STALL_W = 4;

  // extension opcodes as handed over by the core's decode stage.
  // the eighth encoding is left free and is treated as an illegal opcode.
  typedef enum logic [2:0] {
    OP_ADD3       = 3'd0,
    OP_ADD3_STALL = 3'd1,
    OP_ALU        = 3'd2,
    OP_BRJ        = 3'd3,
    OP_LW         = 3'd4,
    OP_SW         = 3'd5,
    OP_EXC        = 3'd6
  } ext_op_t;

  // ALU functions for the register-register operation.
  // the two free encodings produce a zero result.
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_t;

  // one decoded request from the core.
  typedef struct packed {
    ext_op_t             op;
    alu_op_t             alu_fn;
    logic [WORD_W-1:0]   rs0;
    logic [WORD_W-1:0]   rs1;
    logic [IMM_W-1:0]    imm;
  } ext_req_t;

  // the captured request with its opcode expanded into flags.
  // at most one flag is set, and none are set after reset.
  typedef struct packed {
    alu_op_t             alu_fn;
    logic [WORD_W-1:0]   rs0;
    logic [WORD_W-1:0]   rs1;
    logic [IMM_W-1:0]    imm;
    logic                add3;
    logic                add3_stall;
    logic                alu;
    logic                brj;
    logic                lw;
    logic                sw;
    logic                exc;
    logic                illegal;
  } ext_dec_t;

  // result record returned to the core.
  // writeback, branch and memory fields, plus an exception bit.
  typedef struct packed {
    logic                reg_w;
    logic [WORD_W-1:0]   reg_wdata;
    logic                branch_jump;
    logic [WORD_W-1:0]   br_j_addr;
    logic                mem_lw;
    logic                mem_sw;
    logic [WORD_W-1:0]   mem_addr;
    logic [WORD_W-1:0]   mem_store;
    logic                exception;
  } ext_res_t;

endpackage

/* design/ext_alu.sv */
// ext_alu: combinational ALU for the register-register extension operation.

module ext_alu (
  input  ext_pkg::alu_op_t           fn,
  input  logic [ext_pkg::WORD_W-1:0] a,
  input  logic [ext_pkg::WORD_W-1:0] b,
  output logic [ext_pkg::WORD_W-1:0] y
);
  import ext_pkg::*;

  // signed comparison result, widened below to a full word.
  logic lt;

  assign lt = ($signed(a) < $signed(b));

  always_comb begin
    case (fn)
      ALU_ADD: begin
        y = a + b;
      end
      ALU_SUB: begin
        y = a - b;
      end
      ALU_AND: begin
        y = a & b;
      end
      ALU_OR: begin
        y = a | b;
      end
      ALU_XOR: begin
        y = a ^ b;
      end
      ALU_SLT: begin
        // set less than gives 1 or 0 in the low bit.
        y = {{(WORD_W-1){1'b0}}, lt};
      end
      default: begin
        // the two free function codes give zero.
        y = '0;
      end
    endcase
  end

endmodule

/* design/ext_stall_timer.sv */
// ext_stall_timer: loadable down-counter flagging the last cycle of a stalled operation.

module ext_stall_timer (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        start,
  input  logic [ext_pkg::STALL_W-1:0] len,
  output logic                        done
);
  import ext_pkg::*;

  // remaining cycles of the current count.
  logic [STALL_W-1:0] count;

  // set while a count is in progress, so a parked zero count is not a done.
  logic armed;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
      armed <= 1'b0;
    end else if (start) begin
      count <= len;
      armed <= 1'b1;
    end else if (armed) begin
      if (count == '0) begin
        armed <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  // done covers exactly the zero cycle of an armed count.
  assign done = armed && (count == '0);

endmodule

/* design/ext_decode.sv */
// ext_decode: request capture register and opcode to operation flag decoder.

module ext_decode (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              load,
  input  ext_pkg::ext_req_t req,
  output ext_pkg::ext_dec_t dec,
  output logic              stall
);
  import ext_pkg::*;

  // operand payload of the held request.
  alu_op_t             fn_q;
  logic [WORD_W-1:0]   rs0_q;
  logic [WORD_W-1:0]   rs1_q;
  logic [IMM_W-1:0]    imm_q;

  // one flag per operation, decoded at capture time.
  logic add3_q, add3_stall_q, alu_q, brj_q, lw_q, sw_q, exc_q, illegal_q;

  // the flags are cleared by reset so an idle unit decodes to no operation.
  // the free opcode encoding lands in the illegal flag.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      add3_q       <= 1'b0;
      add3_stall_q <= 1'b0;
      alu_q        <= 1'b0;
      brj_q        <= 1'b0;
      lw_q         <= 1'b0;
      sw_q         <= 1'b0;
      exc_q        <= 1'b0;
      illegal_q    <= 1'b0;
    end else if (load) begin
      add3_q       <= (req.op == OP_ADD3);
      add3_stall_q <= (req.op == OP_ADD3_STALL);
      alu_q        <= (req.op == OP_ALU);
      brj_q        <= (req.op == OP_BRJ);
      lw_q         <= (req.op == OP_LW);
      sw_q         <= (req.op == OP_SW);
      exc_q        <= (req.op == OP_EXC);
      illegal_q    <= !(req.op inside {OP_ADD3, OP_ADD3_STALL, OP_ALU, OP_BRJ,
                                       OP_LW, OP_SW, OP_EXC});
    end
  end

  // operand fields of the request, held for the execute stage.
  always_ff @(posedge CLK) begin
    if (load) begin
      fn_q  <= req.alu_fn;
      rs0_q <= req.rs0;
      rs1_q <= req.rs1;
      imm_q <= req.imm;
    end
  end

  // pack the held request for the execute stage.
  always_comb begin
    dec.alu_fn     = fn_q;
    dec.rs0        = rs0_q;
    dec.rs1        = rs1_q;
    dec.imm        = imm_q;
    dec.add3       = add3_q;
    dec.add3_stall = add3_stall_q;
    dec.alu        = alu_q;
    dec.brj        = brj_q;
    dec.lw         = lw_q;
    dec.sw         = sw_q;
    dec.exc        = exc_q;
    dec.illegal    = illegal_q;
  end

  // the control FSM branches into its stall phase on this flag.
  assign stall = add3_stall_q;

endmodule

/* design/ext_execute.sv */
// ext_execute: result record generation from the decoded operation, operands and ALU result.

module ext_execute (
  input  ext_pkg::ext_dec_t          dec,
  input  logic                       done,
  output ext_pkg::alu_op_t           alu_fn,
  output logic [ext_pkg::WORD_W-1:0] alu_a,
  output logic [ext_pkg::WORD_W-1:0] alu_b,
  input  logic [ext_pkg::WORD_W-1:0] alu_y,
  output ext_pkg::ext_res_t          res,
  output logic                       busy
);
  import ext_pkg::*;

  // the immediate is treated as unsigned everywhere.
  logic [WORD_W-1:0] imm_ext;

  // three-operand sum shared by both add operations.
  logic [WORD_W-1:0] add3_sum;

  // effective address of loads and stores.
  logic [WORD_W-1:0] mem_ea;

  assign imm_ext  = {{(WORD_W-IMM_W){1'b0}}, dec.imm};
  assign add3_sum = dec.rs0 + dec.rs1 + imm_ext;
  assign mem_ea   = dec.rs0 + imm_ext;

  // the ALU only sees real operands for the ALU operation.
  // otherwise its inputs sit at zero, which keeps it quiet.
  always_comb begin
    alu_fn = ALU_ADD;
    alu_a  = '0;
    alu_b  = '0;
    if (dec.alu) begin
      alu_fn = dec.alu_fn;
      alu_a  = dec.rs0;
      alu_b  = dec.rs1;
    end
  end

  // every field starts at zero and only the active operation fills its own.
  // the decode flags are exclusive so the order of the branches is free.
  always_comb begin
    res = '0;
    if (dec.add3 || dec.add3_stall) begin
      res.reg_w     = 1'b1;
      res.reg_wdata = add3_sum;
    end else if (dec.alu) begin
      res.reg_w     = 1'b1;
      res.reg_wdata = alu_y;
    end else if (dec.brj) begin
      // the jump target is taken straight from the first source register.
      res.branch_jump = 1'b1;
      res.br_j_addr   = dec.rs0;
    end else if (dec.lw) begin
      res.mem_lw   = 1'b1;
      res.mem_addr = mem_ea;
    end else if (dec.sw) begin
      // stores carry the second source register as write data.
      res.mem_sw    = 1'b1;
      res.mem_addr  = mem_ea;
      res.mem_store = dec.rs1;
    end else if (dec.exc || dec.illegal) begin
      // an unknown opcode is reported to the core the same way as a trap.
      res.exception = 1'b1;
    end
  end

  // a stalled add stays busy until the timer reports the end of its count.
  assign busy = dec.add3_stall && !done;

endmodule

/* design/ext_control.sv */
// ext_control: FSM for the request and result handshakes and the stall phase.

module ext_control (
  input  logic CLK,
  input  logic nRST,
  input  logic req_valid,
  output logic req_ready,
  output logic res_valid,
  input  logic res_ready,
  input  logic stall,
  input  logic done,
  output logic load,
  output logic start
);

  // IDLE waits for a request, EXEC lets the captured request settle.
  // STALL waits on the timer and RESP holds the result until it is taken.
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    EXEC  = 2'd1,
    STALL = 2'd2,
    RESP  = 2'd3
  } state_t;

  state_t state;
  state_t next_state;

  // a request is taken only while idle.
  assign req_ready = (state == IDLE);

  // the result is offered only in RESP, so req_ready and res_valid never overlap.
  assign res_valid = (state == RESP);

  // the decode register captures on the input transfer itself.
  assign load = req_valid && req_ready;

  // start pulses for the single EXEC cycle that leads into STALL.
  // the timer loads on the same edge that enters STALL.
  assign start = (state == EXEC) && stall;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (req_valid) begin
          next_state = EXEC;
        end
      end
      EXEC: begin
        // the decoded flags are valid here and pick the path.
        if (stall) begin
          next_state = STALL;
        end else begin
          next_state = RESP;
        end
      end
      STALL: begin
        if (done) begin
          next_state = RESP;
        end
      end
      RESP: begin
        // back to idle on the edge where the result transfers.
        if (res_ready) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

endmodule

/* design/ext_unit.sv */
// ext_unit: top level of the extension unit with control, timer, decode, execute and ALU.

module ext_unit (
  input  logic              CLK,
  input  logic              nRST,
  input  ext_pkg::ext_req_t req,
  input  logic              req_valid,
  output logic              req_ready,
  output ext_pkg::ext_res_t res,
  output logic              res_valid,
  input  logic              res_ready
);
  import ext_pkg::*;

  // handshake side controls.
  logic load;
  logic start;
  logic stall;
  logic done;

  // captured and decoded request.
  ext_dec_t dec;

  // ALU hookup owned by the execute block.
  alu_op_t           alu_fn;
  logic [WORD_W-1:0] alu_a;
  logic [WORD_W-1:0] alu_b;
  logic [WORD_W-1:0] alu_y;

  // busy is kept inside the unit, where it can be probed.
  logic busy;

  ext_control u_control (
    .CLK       (CLK),
    .nRST      (nRST),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .stall     (stall),
    .done      (done),
    .load      (load),
    .start     (start)
  );

  ext_decode u_decode (
    .CLK   (CLK),
    .nRST  (nRST),
    .load  (load),
    .req   (req),
    .dec   (dec),
    .stall (stall)
  );

  // the stall length is the low immediate bits of the held request.
  ext_stall_timer u_timer (
    .CLK   (CLK),
    .nRST  (nRST),
    .start (start),
    .len   (dec.imm[STALL_W-1:0]),
    .done  (done)
  );

  ext_execute u_execute (
    .dec    (dec),
    .done   (done),
    .alu_fn (alu_fn),
    .alu_a  (alu_a),
    .alu_b  (alu_b),
    .alu_y  (alu_y),
    .res    (res),
    .busy   (busy)
  );

  ext_alu u_alu (
    .fn (alu_fn),
    .a  (alu_a),
    .b  (alu_b),
    .y  (alu_y)
  );

endmodule

/* tests/ext_unit_chk.sv */
// assertion module for the reset and handshake rules of the extension unit.

module ext_unit_chk (
  input logic              CLK,
  input logic              nRST,
  input logic              req_ready,
  input ext_pkg::ext_res_t res,
  input logic              res_valid,
  input logic              res_ready
);

  // count of failed assertions, read by the testbench at the end of the run.
  int assert_fails = 0;

  // no result is offered while the unit is held in reset.
  a_reset_quiet: assert property (@(posedge CLK) !nRST |-> !res_valid)
    else begin
      $error("result offered while reset is asserted");
      assert_fails++;
    end

  // an offered result that is not taken stays offered and unchanged.
  a_res_hold: assert property (@(posedge CLK) disable iff (!nRST)
      (res_valid && !res_ready) |=> (res_valid && $stable(res)))
    else begin
      $error("result dropped or changed under back-pressure");
      assert_fails++;
    end

  // the unit never takes a request while a result is pending.
  a_one_in_flight: assert property (@(posedge CLK) disable iff (!nRST)
      !(req_ready && res_valid))
    else begin
      $error("request side ready while a result is offered");
      assert_fails++;
    end

endmodule

/* tests/ext_unit_tb.sv */
// testbench module for the extension unit: clock, reset, stimulus table, checks and watchdog.

module ext_unit_tb;
  import ext_pkg::*;

  localparam int PERIOD  = 40;
  localparam int N_TESTS = 17;
  localparam int TIMEOUT = N_TESTS * 40 * PERIOD;

  logic     CLK;
  logic     nRST;
  ext_req_t req;
  logic     req_valid;
  logic     req_ready;
  ext_res_t res;
  logic     res_valid;
  logic     res_ready;

  // stimulus table with the expected result and the base back-pressure delay.
  ext_req_t tab_req [N_TESTS];
  ext_res_t tab_res [N_TESTS];
  int       tab_delay [N_TESTS];
  int       n_entries = 0;

  int test_errors = 0;
  int pass_count  = 0;
  int fail_count  = 0;

  ext_unit u_ext_unit (
    .CLK       (CLK),
    .nRST      (nRST),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  bind ext_unit ext_unit_chk u_chk (
    .CLK       (CLK),
    .nRST      (nRST),
    .req_ready (req_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  function automatic ext_req_t mk_req(input ext_op_t op, input alu_op_t fn,
                                      input logic [WORD_W-1:0] rs0,
                                      input logic [WORD_W-1:0] rs1,
                                      input logic [IMM_W-1:0] imm);
    ext_req_t r;
    r        = '0;
    r.op     = op;
    r.alu_fn = fn;
    r.rs0    = rs0;
    r.rs1    = rs1;
    r.imm    = imm;
    return r;
  endfunction

  // each builder returns an expected record with only the fields of its kind set.
  function automatic ext_res_t wb_res(input logic [WORD_W-1:0] data);
    ext_res_t r;
    r           = '0;
    r.reg_w     = 1'b1;
    r.reg_wdata = data;
    return r;
  endfunction

  function automatic ext_res_t br_res(input logic [WORD_W-1:0] target);
    ext_res_t r;
    r             = '0;
    r.branch_jump = 1'b1;
    r.br_j_addr   = target;
    return r;
  endfunction

  function automatic ext_res_t lw_res(input logic [WORD_W-1:0] addr);
    ext_res_t r;
    r          = '0;
    r.mem_lw   = 1'b1;
    r.mem_addr = addr;
    return r;
  endfunction

  function automatic ext_res_t sw_res(input logic [WORD_W-1:0] addr,
                                      input logic [WORD_W-1:0] data);
    ext_res_t r;
    r           = '0;
    r.mem_sw    = 1'b1;
    r.mem_addr  = addr;
    r.mem_store = data;
    return r;
  endfunction

  function automatic ext_res_t exc_res();
    ext_res_t r;
    r           = '0;
    r.exception = 1'b1;
    return r;
  endfunction

  // cycles from the input transfer edge to the first edge with res_valid high.
  function automatic int expected_latency(input ext_req_t r);
    if (r.op == OP_ADD3_STALL) begin
      return 2 + int'(r.imm[STALL_W-1:0]) + 1;
    end
    return 2;
  endfunction

  task automatic add_entry(input ext_req_t r, input ext_res_t e, input int delay);
    tab_req[n_entries]   = r;
    tab_res[n_entries]   = e;
    tab_delay[n_entries] = delay;
    n_entries++;
  endtask

  task automatic flag_error(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    test_errors++;
  endtask

  // expected values follow the add, ALU, branch, memory and exception rules.
  task automatic fill_table();
    add_entry(mk_req(OP_ADD3, ALU_XOR, 32'h0000_0010, 32'h0000_0020, 8'h05), wb_res(32'h35), 0);
    add_entry(mk_req(OP_ALU, ALU_ADD, 32'hFFFF_FFFF, 32'h0000_0002, 8'h00), wb_res(32'h1), 1);
    add_entry(mk_req(OP_ALU, ALU_SUB, 32'h0000_0005, 32'h0000_0007, 8'h3C),
              wb_res(32'hFFFF_FFFE), 0);
    add_entry(mk_req(OP_ALU, ALU_AND, 32'hF0F0_1234, 32'h0FF0_FF00, 8'h00),
              wb_res(32'h00F0_1200), 2);
    add_entry(mk_req(OP_ALU, ALU_OR, 32'hA000_0005, 32'h0500_00A0, 8'h00),
              wb_res(32'hA500_00A5), 0);
    add_entry(mk_req(OP_ALU, ALU_XOR, 32'hFFFF_0000, 32'h0F0F_0F0F, 8'h00),
              wb_res(32'hF0F0_0F0F), 1);
    // signed compares of -2 against 1 and of 3 against -4.
    add_entry(mk_req(OP_ALU, ALU_SLT, 32'hFFFF_FFFE, 32'h0000_0001, 8'h00), wb_res(32'h1), 0);
    add_entry(mk_req(OP_ALU, ALU_SLT, 32'h0000_0003, 32'hFFFF_FFFC, 8'h00), wb_res(32'h0), 3);
    add_entry(mk_req(OP_ALU, alu_op_t'(3'd6), 32'h5, 32'h6, 8'h00), wb_res(32'h0), 0);
    // stalled adds with the shortest, a middle and the longest stall.
    add_entry(mk_req(OP_ADD3_STALL, ALU_ADD, 32'h1, 32'h2, 8'h00), wb_res(32'h3), 1);
    add_entry(mk_req(OP_ADD3_STALL, ALU_ADD, 32'h100, 32'h200, 8'h37), wb_res(32'h337), 0);
    add_entry(mk_req(OP_ADD3_STALL, ALU_ADD, 32'hFFFF_FF00, 32'h1, 8'hFF), wb_res(32'h0), 2);
    add_entry(mk_req(OP_BRJ, ALU_ADD, 32'h8000_0400, 32'h1234, 8'h10),
              br_res(32'h8000_0400), 0);
    add_entry(mk_req(OP_LW, ALU_ADD, 32'h0000_1000, 32'hDEAD_BEEF, 8'h80),
              lw_res(32'h0000_1080), 1);
    add_entry(mk_req(OP_SW, ALU_ADD, 32'h2000_0FFC, 32'hCAFE_F00D, 8'h04),
              sw_res(32'h2000_1000, 32'hCAFE_F00D), 3);
    add_entry(mk_req(OP_EXC, ALU_OR, 32'h1234, 32'h5678, 8'h09), exc_res(), 0);
    add_entry(mk_req(ext_op_t'(3'd7), ALU_ADD, 32'h1, 32'h2, 8'h03), exc_res(), 2);
  endtask

  // watchdog sized from the number of table entries.
  initial begin
    #(TIMEOUT);
    $display("timeout: the run did not finish within %0d time units", TIMEOUT);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int       seed;
    int       cycles;
    int       hold;
    ext_res_t snap;
    seed      = 75513;
    void'($urandom(seed));
    nRST      = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    res_ready = 1'b0;
    fill_table();
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    if (req_ready !== 1'b1 || res_valid !== 1'b0) begin
      flag_error("handshake outputs wrong right after reset");
    end
    $display("reset check: %s", (test_errors == 0) ? "ok" : "wrong");
    if (test_errors == 0) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    for (int i = 0; i < n_entries; i++) begin
      test_errors = 0;
      @(posedge CLK);
      req       <= tab_req[i];
      req_valid <= 1'b1;
      @(negedge CLK);
      while (!req_ready) @(negedge CLK);
      // the request transfers on this edge.
      @(posedge CLK);
      req_valid <= 1'b0;
      req       <= '0;
      cycles = 0;
      do begin
        @(negedge CLK);
        cycles++;
        if (req_ready) begin
          flag_error("unit ready for a new request before the result transferred");
        end
      end while (!res_valid);
      if (cycles != expected_latency(tab_req[i])) begin
        flag_error($sformatf("latency %0d cycles, expected %0d", cycles,
                             expected_latency(tab_req[i])));
      end
      // hold the result under back-pressure and watch that nothing moves.
      snap = res;
      hold = tab_delay[i] + int'($urandom % 4);
      repeat (hold) begin
        @(negedge CLK);
        if (!res_valid || req_ready || res !== snap) begin
          flag_error("result dropped or changed while res_ready was low");
        end
      end
      @(posedge CLK);
      res_ready <= 1'b1;
      @(negedge CLK);
      if (!res_valid || res !== tab_res[i]) begin
        flag_error($sformatf("res %h, expected %h", res, tab_res[i]));
      end
      @(posedge CLK);
      res_ready <= 1'b0;
      @(negedge CLK);
      if (res_valid || !req_ready) begin
        flag_error("unit did not return to idle after the result transferred");
      end
      $display("test %0d op %0d latency %0d hold %0d: %s", i, tab_req[i].op, cycles, hold,
               (test_errors == 0) ? "ok" : "wrong");
      if (test_errors == 0) begin
        pass_count++;
      end else begin
        fail_count++;
      end
    end
    $display("tests passed %0d, failed %0d, assertion failures %0d", pass_count, fail_count,
             u_ext_unit.u_chk.assert_fails);
    if (fail_count == 0 && u_ext_unit.u_chk.assert_fails == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* ext_unit.f */
design/ext_pkg.sv
design/ext_alu.sv
design/ext_stall_timer.sv
design/ext_decode.sv
design/ext_execute.sv
design/ext_control.sv
design/ext_unit.sv
tests/ext_unit_chk.sv
tests/ext_unit_tb.sv
